/* build.f */
design/rv_pkg.sv
design/rv_fetch.sv
design/rv_instr_buf.sv
design/rv_exec.sv
design/rv_regs.sv
design/rv_core.sv
sim/tb_rv_core.sv

/* design/rv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core
#(
    parameter int           IADDR_SPACE_BITS    = 16,
    parameter logic [31:0]  RESET_ADDR          = 32'h0000_0000,
    parameter int           INSTR_BUF_ADDR_SIZE = 2  // depth is 2**N words
)
(
    input  wire                           i_clk,
    input  wire                           i_rst_n,
    input  wire                           i_instr_ack,
    input  wire [rv_pkg::ILEN-1:0]        i_instr_data,
    output wire                           o_instr_req,
    output wire [IADDR_SPACE_BITS-1:1]    o_instr_addr,
    output wire                           o_wb_valid,
    output wire [rv_pkg::REG_ADDR_W-1:0]  o_wb_rd,
    output wire [rv_pkg::XLEN-1:0]        o_wb_data,
    output wire                           o_inv_inst
);

    wire                          buf_full;
    wire                          buf_valid;
    wire [rv_pkg::ILEN-1:0]       buf_data;
    wire                          push;
    wire                          pop;
    wire                          rf_we;
    wire [rv_pkg::REG_ADDR_W-1:0] rs1;
    wire [rv_pkg::REG_ADDR_W-1:0] rs2;
    wire [rv_pkg::REG_ADDR_W-1:0] rf_rd;
    wire [rv_pkg::XLEN-1:0]       rf_wdata;
    wire [rv_pkg::XLEN-1:0]       rdata1;
    wire [rv_pkg::XLEN-1:0]       rdata2;

    rv_fetch #(
        .IADDR_SPACE_BITS   (IADDR_SPACE_BITS),
        .RESET_ADDR         (RESET_ADDR)
    ) u_fetch (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_buf_full     (buf_full),
        .i_instr_ack    (i_instr_ack),
        .o_instr_req    (o_instr_req),
        .o_instr_addr   (o_instr_addr),
        .o_push         (push)
    );

    rv_instr_buf #(
        .INSTR_BUF_ADDR_SIZE(INSTR_BUF_ADDR_SIZE)
    ) u_instr_buf (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_push     (push),
        .i_pop      (pop),
        .i_data     (i_instr_data),
        .o_data     (buf_data),
        .o_full     (buf_full),
        .o_valid    (buf_valid)
    );

    rv_exec u_exec (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (buf_valid),
        .i_instr    (buf_data),
        .i_rdata1   (rdata1),
        .i_rdata2   (rdata2),
        .o_pop      (pop),
        .o_rf_we    (rf_we),
        .o_rs1      (rs1),
        .o_rs2      (rs2),
        .o_rf_rd    (rf_rd),
        .o_rf_wdata (rf_wdata),
        .o_wb_valid (o_wb_valid),
        .o_wb_rd    (o_wb_rd),
        .o_wb_data  (o_wb_data),
        .o_inv_inst (o_inv_inst)
    );

    rv_regs u_regs (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_we       (rf_we),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .i_rd       (rf_rd),
        .i_wdata    (rf_wdata),
        .o_rdata1   (rdata1),
        .o_rdata2   (rdata2)
    );

endmodule

`default_nettype wire

/* design/rv_exec.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_exec
(
    input  wire                           i_clk,
    input  wire                           i_rst_n,
    input  wire                           i_valid,
    input  wire [rv_pkg::ILEN-1:0]        i_instr,
    input  wire [rv_pkg::XLEN-1:0]        i_rdata1,
    input  wire [rv_pkg::XLEN-1:0]        i_rdata2,
    output logic                          o_pop,
    output logic                          o_rf_we,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rs1,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rs2,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rf_rd,
    output logic [rv_pkg::XLEN-1:0]       o_rf_wdata,
    output logic                          o_wb_valid,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_wb_rd,
    output logic [rv_pkg::XLEN-1:0]       o_wb_data,
    output logic                          o_inv_inst
);

    rv_pkg::rv_opcode_e     opcode;
    rv_pkg::rv_alu_op_e     alu_op;
    rv_pkg::rv_exec_state_e state_q;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic                   is_reg_op;
    logic                   supported;
    logic                   is_shift;
    logic [rv_pkg::XLEN-1:0] imm_i;
    logic [rv_pkg::XLEN-1:0] op2;
    logic [rv_pkg::XLEN-1:0] alu_res;
    logic [rv_pkg::XLEN-1:0] sh_data_q;
    logic [4:0]             sh_cnt_q;

    assign opcode    = rv_pkg::rv_opcode_e'(i_instr[6:0]);
    assign funct3    = i_instr[14:12];
    assign funct7    = i_instr[31:25];
    assign o_rs1     = i_instr[19:15];
    assign o_rs2     = i_instr[24:20];
    assign o_rf_rd   = i_instr[11:7];
    assign is_reg_op = (opcode == rv_pkg::OPC_OP);
    assign imm_i     = {{(rv_pkg::XLEN-12){i_instr[31]}}, i_instr[31:20]};
    assign op2       = is_reg_op ? i_rdata2 : imm_i;

    always_comb begin
        alu_op    = rv_pkg::ALU_ADD;
        supported = 1'b1;
        case (opcode)
            rv_pkg::OPC_LUI: alu_op = rv_pkg::ALU_LUI;
            rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM: begin
                case (funct3)
                    3'd0: alu_op = (is_reg_op && funct7[5]) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'd1: alu_op = rv_pkg::ALU_SLL;
                    3'd2: alu_op = rv_pkg::ALU_SLT;
                    3'd3: alu_op = rv_pkg::ALU_SLTU;
                    3'd4: alu_op = rv_pkg::ALU_XOR;
                    3'd5: alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    3'd6: alu_op = rv_pkg::ALU_OR;
                    default: alu_op = rv_pkg::ALU_AND;
                endcase
                // funct7 must be 0, or 0100000 for sub/sra
                if (is_reg_op || funct3 == 3'd1 || funct3 == 3'd5) begin
                    supported = (funct7 == 7'b0000000) ||
                                (funct7 == 7'b0100000 &&
                                 (funct3 == 3'd5 || (is_reg_op && funct3 == 3'd0)));
                end
            end
            default: supported = 1'b0;
        endcase
    end

    assign is_shift = supported && (alu_op == rv_pkg::ALU_SLL ||
                                     alu_op == rv_pkg::ALU_SRL ||
                                     alu_op == rv_pkg::ALU_SRA);

    always_comb begin
        case (alu_op)
            rv_pkg::ALU_ADD:  alu_res = i_rdata1 + op2;
            rv_pkg::ALU_SUB:  alu_res = i_rdata1 - op2;
            rv_pkg::ALU_SLT:  alu_res = {{(rv_pkg::XLEN-1){1'b0}}, $signed(i_rdata1) < $signed(op2)};
            rv_pkg::ALU_SLTU: alu_res = {{(rv_pkg::XLEN-1){1'b0}}, i_rdata1 < op2};
            rv_pkg::ALU_XOR:  alu_res = i_rdata1 ^ op2;
            rv_pkg::ALU_OR:   alu_res = i_rdata1 | op2;
            rv_pkg::ALU_AND:  alu_res = i_rdata1 & op2;
            rv_pkg::ALU_LUI:  alu_res = {i_instr[31:12], 12'b0};
            default:          alu_res = sh_data_q;
        endcase
    end

    // serial shifter, one bit per cycle in EX_SHIFT
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q  <= rv_pkg::EX_RUN;
            sh_cnt_q <= '0;
        end else if (state_q == rv_pkg::EX_RUN) begin
            if (i_valid && is_shift) begin
                state_q  <= rv_pkg::EX_SHIFT;
                sh_cnt_q <= op2[4:0];
            end
        end else if (sh_cnt_q != '0) begin
            sh_cnt_q <= sh_cnt_q - 1'b1;
        end else begin
            state_q <= rv_pkg::EX_RUN;
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_q == rv_pkg::EX_RUN) begin
            sh_data_q <= i_rdata1;
        end else if (sh_cnt_q != '0) begin
            case (alu_op)
                rv_pkg::ALU_SLL: sh_data_q <= {sh_data_q[rv_pkg::XLEN-2:0], 1'b0};
                rv_pkg::ALU_SRA: sh_data_q <= {sh_data_q[rv_pkg::XLEN-1],
                                               sh_data_q[rv_pkg::XLEN-1:1]};
                default:         sh_data_q <= {1'b0, sh_data_q[rv_pkg::XLEN-1:1]};
            endcase
        end
    end

    // head word is stable until popped, so decode stays valid during a shift
    assign o_pop = i_valid && ((state_q == rv_pkg::EX_RUN && !is_shift) ||
                               (state_q == rv_pkg::EX_SHIFT && sh_cnt_q == '0));
    assign o_rf_we    = o_pop && supported;
    assign o_rf_wdata = alu_res;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_valid <= 1'b0;
            o_inv_inst <= 1'b0;
        end else begin
            o_wb_valid <= o_rf_we && (o_rf_rd != '0);
            o_inv_inst <= o_pop && !supported;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_rf_we) begin
            o_wb_rd   <= o_rf_rd;
            o_wb_data <= o_rf_wdata;
        end
    end

    // buffer keeps the shifting word at its head
    a_shift_valid: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        state_q == rv_pkg::EX_SHIFT |-> i_valid
    );

    a_shift_hold: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        state_q == rv_pkg::EX_SHIFT |-> $stable(i_instr)
    );

endmodule

`default_nettype wire

/* design/rv_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_fetch
#(
    parameter int           IADDR_SPACE_BITS = 16,
    parameter logic [31:0]  RESET_ADDR       = 32'h0000_0000
)
(
    input  wire                         i_clk,
    input  wire                         i_rst_n,
    input  wire                         i_buf_full,
    input  wire                         i_instr_ack,
    output logic                        o_instr_req,
    output logic [IADDR_SPACE_BITS-1:1] o_instr_addr,
    output logic                        o_push
);

    logic                        run_q;
    logic [IADDR_SPACE_BITS-1:1] addr_q;

    // goes high one clock after reset release
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // full only rises on a push, so req cannot drop mid-request
    assign o_instr_req = run_q & ~i_buf_full;
    assign o_push      = o_instr_req & i_instr_ack;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            addr_q <= RESET_ADDR[IADDR_SPACE_BITS-1:1];
        end else if (o_push) begin
            // one word is two halfwords
            addr_q <= addr_q + (IADDR_SPACE_BITS-1)'(2);
        end
    end

    assign o_instr_addr = addr_q;

    // pending request keeps its address until acked
    a_req_hold: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_instr_req && !i_instr_ack |=> o_instr_req && $stable(o_instr_addr)
    );

endmodule

`default_nettype wire

/* design/rv_instr_buf.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_instr_buf
#(
    parameter int INSTR_BUF_ADDR_SIZE = 2
)
(
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  wire                     i_push,
    input  wire                     i_pop,
    input  wire [rv_pkg::ILEN-1:0]  i_data,
    output logic [rv_pkg::ILEN-1:0] o_data,
    output logic                    o_full,
    output logic                    o_valid
);

    localparam logic [INSTR_BUF_ADDR_SIZE:0] DEPTH = 1 << INSTR_BUF_ADDR_SIZE;

    logic [rv_pkg::ILEN-1:0]        mem [0:(1<<INSTR_BUF_ADDR_SIZE)-1];
    logic [INSTR_BUF_ADDR_SIZE-1:0] wr_ptr;
    logic [INSTR_BUF_ADDR_SIZE-1:0] rd_ptr;
    logic [INSTR_BUF_ADDR_SIZE:0]   count;
    logic [INSTR_BUF_ADDR_SIZE:0]   count_next;

    always_comb begin
        case ({i_push, i_pop})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            o_full <= 1'b0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count  <= count_next;
            o_full <= (count_next == DEPTH);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    // head word, visible the cycle after its push
    assign o_data  = mem[rd_ptr];
    assign o_valid = (count != '0);

    a_no_overflow: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) i_push |-> !o_full
    );

    a_no_underflow: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) i_pop |-> o_valid
    );

endmodule

`default_nettype wire

/* design/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // data and instruction widths
    localparam int XLEN       = 32;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;

    // major opcode field, instr[6:0]
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111
    } rv_opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_AND  = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9,
        ALU_LUI  = 4'd10
    } rv_alu_op_e;

    // shifts leave EX_RUN for the serial shifter
    typedef enum logic [0:0] {
        EX_RUN   = 1'b0,
        EX_SHIFT = 1'b1
    } rv_exec_state_e;

endpackage

`default_nettype wire

/* design/rv_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_regs
(
    input  wire                          i_clk,
    input  wire                          i_rst_n,
    input  wire                          i_we,
    input  wire [rv_pkg::REG_ADDR_W-1:0] i_rs1,
    input  wire [rv_pkg::REG_ADDR_W-1:0] i_rs2,
    input  wire [rv_pkg::REG_ADDR_W-1:0] i_rd,
    input  wire [rv_pkg::XLEN-1:0]       i_wdata,
    output logic [rv_pkg::XLEN-1:0]      o_rdata1,
    output logic [rv_pkg::XLEN-1:0]      o_rdata2
);

    // x0 has no storage
    logic [rv_pkg::XLEN-1:0] regs [1:31];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_rd != '0) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // combinational read, written value seen after the edge
    always_comb begin
        if (i_rs1 == '0) begin
            o_rdata1 = '0;
        end else begin
            o_rdata1 = regs[i_rs1];
        end
        if (i_rs2 == '0) begin
            o_rdata2 = '0;
        end else begin
            o_rdata2 = regs[i_rs2];
        end
    end

endmodule

`default_nettype wire

/* sim/tb_rv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;

    localparam int BUF_ADDR_SIZE  = 2;
    localparam int DEPTH          = 1 << BUF_ADDR_SIZE;
    localparam int N_WORDS        = 400;
    localparam int TIMEOUT_CYCLES = N_WORDS * 16 + 200;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_instr_ack;
    logic [31:0] i_instr_data;
    wire         o_instr_req;
    wire  [15:1] o_instr_addr;
    wire         o_wb_valid;
    wire  [4:0]  o_wb_rd;
    wire  [31:0] o_wb_data;
    wire         o_inv_inst;

    logic [15:0] lfsr;
    logic [31:0] mregs [0:31];
    logic [31:0] fetch_q [$];
    // {invalid, rd, data}
    logic [37:0] exp_q [$];
    logic [37:0] exp_ev;
    logic [31:0] ack_word;
    logic [31:0] rnd;
    logic [15:1] exp_addr;
    logic        ack_drv;
    logic        req_seen;
    int          wait_cnt;
    int          sh_left;
    int          n_acked;
    int          n_retired;
    int          n_exp_events;
    int          n_dut_events;
    int          n_mismatch;
    int          n_other;
    int          cycles;

    rv_core i_rv_core (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_instr_ack  (i_instr_ack),
        .i_instr_data (i_instr_data),
        .o_instr_req  (o_instr_req),
        .o_instr_addr (o_instr_addr),
        .o_wb_valid   (o_wb_valid),
        .o_wb_rd      (o_wb_rd),
        .o_wb_data    (o_wb_data),
        .o_inv_inst   (o_inv_inst)
    );

    always #2 i_clk = ~i_clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic legal(input logic [31:0] w);
        logic [6:0] f7;
        f7 = w[31:25];
        legal = 1'b1;
        if (w[6:0] == 7'b0110011) begin
            legal = (f7 == 7'h00) || (f7 == 7'h20 && (w[14:12] == 3'd0 || w[14:12] == 3'd5));
        end else if (w[6:0] == 7'b0010011) begin
            if (w[14:12] == 3'd1) begin
                legal = (f7 == 7'h00);
            end else if (w[14:12] == 3'd5) begin
                legal = (f7 == 7'h00) || (f7 == 7'h20);
            end
        end else if (w[6:0] != 7'b0110111) begin
            legal = 1'b0;
        end
    endfunction

    // -1 for anything that is not a legal shift
    function automatic int shift_amount(input logic [31:0] w);
        logic [31:0] amt;
        amt = (w[6:0] == 7'b0110011) ? mregs[w[24:20]] : {27'd0, w[24:20]};
        if (!legal(w) || w[6:0] == 7'b0110111 || (w[14:12] != 3'd1 && w[14:12] != 3'd5)) begin
            shift_amount = -1;
        end else begin
            shift_amount = int'(amt[4:0]);
        end
    endfunction

    task automatic retire_model(input logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [6:0]  f7;
        a = mregs[w[19:15]];
        b = (w[6:0] == 7'b0110011) ? mregs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        f7 = w[31:25];
        case (w[14:12])
            3'd0: res = (w[6:0] == 7'b0110011 && f7 == 7'h20) ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = {31'd0, $signed(a) < $signed(b)};
            3'd3: res = {31'd0, a < b};
            3'd4: res = a ^ b;
            3'd5: begin
                if (f7[5]) begin
                    res = $signed(a) >>> b[4:0];
                end else begin
                    res = a >> b[4:0];
                end
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        if (w[6:0] == 7'b0110111) begin
            res = {w[31:12], 12'h000};
        end
        n_retired++;
        if (!legal(w)) begin
            exp_q.push_back({1'b1, 5'd0, 32'd0});
            n_exp_events++;
        end else if (w[11:7] != 5'd0) begin
            mregs[w[11:7]] = res;
            exp_q.push_back({1'b0, w[11:7], res});
            n_exp_events++;
        end
    endtask

    task automatic make_word(output logic [31:0] w);
        logic [31:0] r;
        logic [1:0]  kind;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        take_bits(4, r);
        if (r[3:0] == 4'd0) begin
            take_bits(32, r);
            if (r[6:0] == 7'b0010011 || r[6:0] == 7'b0110011 || r[6:0] == 7'b0110111) begin
                r[6:0] = 7'b1111111;
            end
            w = r;
        end else begin
            take_bits(2, r);
            kind = r[1:0];
            take_bits(3, r);
            f3 = r[2:0];
            take_bits(5, r);
            rd = r[4:0];
            take_bits(5, r);
            rs1 = r[4:0];
            take_bits(5, r);
            rs2 = r[4:0];
            take_bits(1, r);
            f7 = (r[0] && (f3 == 3'd5 || (kind == 2'd1 && f3 == 3'd0))) ? 7'h20 : 7'h00;
            if (kind == 2'd0) begin
                take_bits(20, r);
                w = {r[19:0], rd, 7'b0110111};
            end else if (kind == 2'd1) begin
                w = {f7, rs2, rs1, f3, rd, 7'b0110011};
            end else if (f3 == 3'd1 || f3 == 3'd5) begin
                // immediate shifts stay below 8
                w = {f7, 2'b00, rs2[2:0], rs1, f3, rd, 7'b0010011};
            end else begin
                take_bits(12, r);
                w = {r[11:0], rs1, f3, rd, 7'b0010011};
            end
        end
    endtask

    always @(negedge i_clk) begin
        if (i_rst_n) begin
            // buffer and execute timing for the edge just passed
            if (fetch_q.size() != 0) begin
                if (sh_left < 0) begin
                    sh_left = shift_amount(fetch_q[0]);
                    if (sh_left < 0) begin
                        retire_model(fetch_q.pop_front());
                    end
                end else if (sh_left == 0) begin
                    sh_left = -1;
                    retire_model(fetch_q.pop_front());
                end else begin
                    sh_left--;
                end
            end
            if (ack_drv) begin
                fetch_q.push_back(ack_word);
                ack_drv = 1'b0;
            end
            // reports were registered at that same edge
            if (o_wb_valid || o_inv_inst) begin
                n_dut_events++;
            end
            if (o_wb_valid) begin
                if (exp_q.size() == 0 || exp_q[0][37]) begin
                    $display("unexpected register write to x%0d", o_wb_rd);
                    n_other++;
                end else begin
                    exp_ev = exp_q.pop_front();
                    if (o_wb_rd !== exp_ev[36:32]) begin
                        $display("MISMATCH o_wb_rd: got %h expected %h", o_wb_rd, exp_ev[36:32]);
                        n_mismatch++;
                    end
                    if (o_wb_data !== exp_ev[31:0]) begin
                        $display("MISMATCH o_wb_data: got %h expected %h", o_wb_data, exp_ev[31:0]);
                        n_mismatch++;
                    end
                end
            end
            if (o_inv_inst) begin
                if (exp_q.size() == 0 || !exp_q[0][37]) begin
                    $display("unexpected o_inv_inst pulse");
                    n_other++;
                end else begin
                    exp_ev = exp_q.pop_front();
                end
            end
            if (exp_q.size() != 0) begin
                $display("expected %s is missing",
                         exp_q[0][37] ? "o_inv_inst pulse" : "register write");
                n_other++;
                exp_q.delete();
            end
            if (fetch_q.size() > DEPTH) begin
                $display("%0d words in flight, buffer holds only %0d", fetch_q.size(), DEPTH);
                n_other++;
            end
            if (fetch_q.size() == DEPTH && o_instr_req) begin
                $display("request raised while the buffer is full");
                n_other++;
            end
            // memory side
            i_instr_ack = 1'b0;
            if (o_instr_req && n_acked < N_WORDS) begin
                if (!req_seen) begin
                    req_seen = 1'b1;
                    take_bits(2, rnd);
                    wait_cnt = rnd[1:0];
                    if (o_instr_addr !== exp_addr) begin
                        $display("MISMATCH o_instr_addr: got %h expected %h",
                                 o_instr_addr, exp_addr);
                        n_mismatch++;
                    end
                end
                if (wait_cnt == 0) begin
                    make_word(ack_word);
                    i_instr_ack  = 1'b1;
                    i_instr_data = ack_word;
                    ack_drv      = 1'b1;
                    req_seen     = 1'b0;
                    n_acked++;
                    exp_addr = exp_addr + 15'd2;
                end else begin
                    wait_cnt--;
                end
            end else if (req_seen) begin
                $display("request dropped before its ack");
                n_other++;
                req_seen = 1'b0;
            end
        end
    end

    always @(posedge i_clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d of %0d words retired",
                     cycles, n_retired, N_WORDS);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        i_clk        = 1'b0;
        i_rst_n      = 1'b0;
        i_instr_ack  = 1'b0;
        i_instr_data = '0;
        lfsr         = 16'd49138;
        exp_addr     = 15'd0;
        ack_drv      = 1'b0;
        req_seen     = 1'b0;
        sh_left      = -1;
        for (int r = 0; r < 32; r++) begin
            mregs[r] = '0;
        end
        repeat (10) @(negedge i_clk);
        if (o_instr_req || o_wb_valid || o_inv_inst) begin
            $display("outputs not idle during reset");
            n_other++;
        end
        i_rst_n = 1'b1;
        while (!(n_acked == N_WORDS && n_retired == N_WORDS && exp_q.size() == 0)) begin
            @(posedge i_clk);
        end
        // drain, catches late or stray reports
        repeat (8) @(posedge i_clk);
        if (n_dut_events != n_exp_events) begin
            $display("saw %0d of %0d reported events for %0d retired words",
                     n_dut_events, n_exp_events, n_retired);
            n_other++;
        end
        $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
        if (n_mismatch + n_other == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
